// File: sim.f
verilog/pt_walk_pkg.sv
verilog/pt_walk_rsp_stage.sv
verilog/pt_walk_fsm.sv
verilog/pt_walker.sv
sim/pt_walker_sva.sv
sim/tb_pt_walker.sv

// File: Bender.yml
package:
  name: pt_walker

sources:
  # Walker RTL, package first
  - verilog/pt_walk_pkg.sv
  - verilog/pt_walk_rsp_stage.sv
  - verilog/pt_walk_fsm.sv
  - verilog/pt_walker.sv

  # Testbench and bound assertions
  - target: test
    files:
      - sim/pt_walker_sva.sv
      - sim/tb_pt_walker.sv

// File: sim/tb_pt_walker.sv
/*
 * Testbench for the page-table walker.
 * Builds page tables in a line-addressed memory model, runs translation
 * requests through the DUT and checks read addresses, fills and readiness
 * with concurrent assertions. A cycle limit ends a stalled run.
 */
`timescale 1ns/1ps

module tb_pt_walker;
    import pt_walk_pkg::*;

    localparam int RESET_CYCLES  = 5;
    localparam int NUM_RANDOM    = 30;
    localparam int NUM_BACKPRESS = 5;
    // Walks x levels x worst cycles per level, plus reset, enable and fill holds
    localparam int TIMEOUT_CYCLES = 40 * PT_LEVELS * 12 + 600;

    logic       clk = 1'b0;
    logic       reset;
    pa_page_t   pt_root;
    logic       enable;
    logic       req_en;
    va_page_t   req_va;
    logic       req_rdy;
    logic       read_rdy = 1'b1;
    logic       read_en;
    line_addr_t read_addr;
    logic       read_data_en = 1'b0;
    line_data_t read_data = '0;
    logic       fill_rdy;
    logic       fill_en;
    pt_fill_t   fill;
    logic       not_present;
    logic       busy;

    // Table memory, one 512-bit line per key
    line_data_t mem [line_addr_t];

    integer     seed = 32'h6c106b0b;
    pa_page_t   next_page;
    pt_fill_t   exp_fill;
    line_addr_t exp_addrs [PT_LEVELS];
    int         rd_cnt;
    int         fill_cnt;
    int         np_cnt;
    int         cycles;
    int         errors;
    int         tests;
    bit         rdy_gaps;
    bit         expect_fault;
    bit         halted;

    // Walk in flight from accepted request to fill, and for good after a fault
    bit         walk_on = 1'b0;

    // Read captured at the clock edge, response countdown
    logic       rd_seen = 1'b0;
    line_addr_t rd_seen_addr;
    int         rsp_wait;
    line_addr_t rsp_addr;

    pt_walker u_dut (.*);

    always #4 clk = ~clk;

    // ============================================================
    // Memory model and monitors
    // ============================================================

    // Unwritten lines hold error entries tagged with the line address
    function automatic line_data_t blank_line(line_addr_t addr);
        pt_word_t w;
        w = {addr, 22'h000008};
        return {PT_WORDS_PER_LINE{w}};
    endfunction

    always @(posedge clk)
    begin
        rd_seen      <= !reset && read_en;
        rd_seen_addr <= read_addr;
        // Read index restarts with each accepted request
        if (req_en && req_rdy)
            rd_cnt <= 0;
        else if (read_en)
            rd_cnt <= rd_cnt + 1;
        if (req_en && req_rdy)
            walk_on <= 1'b1;
        else if (fill_en)
            walk_on <= 1'b0;
        if (fill_en)
            fill_cnt <= fill_cnt + 1;
        if (not_present)
            np_cnt <= np_cnt + 1;
    end

    // One response per read after 1 to 4 cycles
    always @(negedge clk)
    begin
        read_data_en = 1'b0;
        if (rd_seen)
        begin
            rsp_addr = rd_seen_addr;
            rsp_wait = 1 + {$random(seed)} % 4;
        end
        if (rsp_wait != 0)
        begin
            rsp_wait = rsp_wait - 1;
            if (rsp_wait == 0)
            begin
                read_data_en = 1'b1;
                if (mem.exists(rsp_addr))
                    read_data = mem[rsp_addr];
                else
                    read_data = blank_line(rsp_addr);
            end
        end
        // Ready gaps about one cycle in three
        read_rdy = rdy_gaps ? ({$random(seed)} % 3 != 0) : 1'b1;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: walker made no progress within %0d cycles", cycles);
            $display(">>> FAIL");
            $finish;
        end
    end

    // ============================================================
    // Checks
    // ============================================================

    a_fill: assert property (@(posedge clk) disable iff (reset) fill_en |-> fill == exp_fill)
    else
    begin
        errors++;
        $display("[ERROR] %0t: fill %h, expected %h", $time, fill, exp_fill);
    end

    // Current page joined with the line part of the level index
    a_read_addr: assert property (@(posedge clk) disable iff (reset)
        read_en |-> read_addr == exp_addrs[rd_cnt])
    else
    begin
        errors++;
        $display("[ERROR] %0t: read_addr %h at read %0d, expected %h",
                 $time, read_addr, rd_cnt, exp_addrs[rd_cnt]);
    end

    a_fill_stable: assert property (@(posedge clk) disable iff (reset)
        (u_dut.u_fsm.state == DONE && !fill_rdy) |=> $stable(fill))
    else
    begin
        errors++;
        $display("[ERROR] %0t: fill changed while held by fill_rdy", $time);
    end

    a_rdy_enable: assert property (@(posedge clk) disable iff (reset)
        !$past(enable) |-> !req_rdy)
    else
    begin
        errors++;
        $display("[ERROR] %0t: req_rdy high before enable", $time);
    end

    a_rdy_after_fill: assert property (@(posedge clk) disable iff (reset) fill_en |=> req_rdy)
    else
    begin
        errors++;
        $display("[ERROR] %0t: req_rdy low after fill_en", $time);
    end

    // Busy level follows the walk from request to fill
    a_busy: assert property (@(posedge clk) disable iff (reset) busy == walk_on)
    else
    begin
        errors++;
        $display("[ERROR] %0t: busy %b, expected %b", $time, $sampled(busy),
                 $sampled(walk_on));
    end

    a_no_fill: assert property (@(posedge clk) disable iff (reset) expect_fault |-> !fill_en)
    else
    begin
        errors++;
        $display("[ERROR] %0t: fill_en during a faulting walk", $time);
    end

    a_halted: assert property (@(posedge clk) disable iff (reset) halted |-> !req_rdy)
    else
    begin
        errors++;
        $display("[ERROR] %0t: req_rdy high after not_present", $time);
    end

    // ============================================================
    // Table builder and walk tasks
    // ============================================================

    function automatic pa_page_t alloc_page();
        next_page = next_page + pa_page_t'(1 + {$random(seed)} % 16);
        return next_page;
    endfunction

    function automatic int total_errors();
        return errors + u_dut.u_sva.fail_count;
    endfunction

    task automatic write_entry(input line_addr_t addr, input pt_word_idx_t w,
                               input pt_word_t val);
        line_data_t line;
        if (mem.exists(addr))
            line = mem[addr];
        else
            line = blank_line(addr);
        line[w*PT_WORD_W +: PT_WORD_W] = val;
        mem[addr] = line;
    endtask

    // Levels 3 ends in a 2 MB page, 4 in a 4 KB page
    // A fault level below levels puts an error entry there
    task automatic build_table(input pa_page_t root, input va_page_t va, input int levels,
                               input int fault_lvl, output pa_page_t leaf);
        pa_page_t   page;
        pa_page_t   next;
        pt_idx_t    idx;
        line_addr_t addr;
        pt_word_t   word;
        page = root;
        for (int lvl = 0; lvl < levels; lvl++)
        begin
            idx  = va[(PT_LEVELS-1-lvl)*PT_IDX_W +: PT_IDX_W];
            addr = {page, idx[PT_IDX_W-1 -: PT_LINE_IDX_W]};
            next = alloc_page();
            word = {16'h0, next, 12'h000};
            exp_addrs[lvl] = addr;
            if (lvl == fault_lvl)
                word[PT_ERROR_BIT] = 1'b1;
            else if (lvl == levels - 1)
                word[PT_TERMINAL_BIT] = 1'b1;
            write_entry(addr, idx[PT_WORD_IDX_W-1:0], word);
            if (lvl == fault_lvl)
                break;
            page = next;
        end
        leaf = page;
    endtask

    // One-cycle request strobe once the walker is ready
    task automatic issue_request(input pa_page_t root, input va_page_t va);
        while (!req_rdy)
            @(negedge clk);
        pt_root = root;
        req_va  = va;
        req_en  = 1'b1;
        @(negedge clk);
        req_en  = 1'b0;
    endtask

    task automatic run_walk(input va_page_t va, input int levels, input bit hold_fill);
        pa_page_t root;
        pa_page_t leaf;
        int       fills_before;
        root = alloc_page();
        build_table(root, va, levels, PT_LEVELS, leaf);
        exp_fill.va       = va;
        exp_fill.pa       = leaf;
        exp_fill.big_page = (levels == 3);
        fill_rdy     = !hold_fill;
        fills_before = fill_cnt;
        issue_request(root, va);
        if (hold_fill)
        begin
            while (u_dut.u_fsm.state != DONE)
                @(negedge clk);
            repeat (3 + {$random(seed)} % 6) @(negedge clk);
            fill_rdy = 1'b1;
        end
        while (fill_cnt == fills_before)
            @(negedge clk);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests++;
        if (total_errors() == errs_before)
            $display("Test %-14s ok", name);
        else
            $display("Test %-14s failed with %0d errors", name, total_errors() - errs_before);
    endtask

    // ============================================================
    // Test sequence
    // ============================================================

    initial
    begin
        int       errs;
        va_page_t va;
        pa_page_t root;
        pa_page_t leaf;
        reset        = 1'b1;
        enable       = 1'b0;
        req_en       = 1'b0;
        req_va       = '0;
        pt_root      = '0;
        fill_rdy     = 1'b1;
        rdy_gaps     = 1'b0;
        expect_fault = 1'b0;
        halted       = 1'b0;
        next_page    = 36'h0_0010_0000;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;

        // Walker stays unready until enable has been registered
        errs = total_errors();
        repeat (4) @(negedge clk);
        enable = 1'b1;
        run_walk(36'h0_1234_5678, 4, 1'b0);
        report_test("readiness", errs);

        errs = total_errors();
        run_walk(36'h0_2468_ace1, 4, 1'b0);
        report_test("walk_4k", errs);

        errs = total_errors();
        run_walk(36'h9_8765_4321, 3, 1'b0);
        report_test("walk_2m", errs);

        errs = total_errors();
        for (int i = 0; i < NUM_RANDOM; i++)
        begin
            va = va_page_t'({$random(seed), $random(seed)});
            run_walk(va, ($random(seed) & 1) ? 4 : 3, 1'b0);
        end
        report_test("random_va", errs);

        errs = total_errors();
        rdy_gaps = 1'b1;
        for (int i = 0; i < NUM_BACKPRESS; i++)
        begin
            va = va_page_t'({$random(seed), $random(seed)});
            run_walk(va, 4, 1'b1);
        end
        rdy_gaps = 1'b0;
        report_test("backpressure", errs);

        // Error entry at level 1, walker halts afterwards
        errs = total_errors();
        va   = va_page_t'({$random(seed), $random(seed)});
        root = alloc_page();
        build_table(root, va, 4, 1, leaf);
        expect_fault = 1'b1;
        issue_request(root, va);
        while (np_cnt == 0)
            @(negedge clk);
        halted = 1'b1;
        repeat (10) @(negedge clk);
        a_np_once: assert (np_cnt == 1)
        else
        begin
            errors++;
            $display("[ERROR] %0t: %0d not_present pulses, expected 1", $time, np_cnt);
        end
        report_test("missing_entry", errs);

        $display("Summary: %0d tests run, %0d errors", tests, total_errors());
        if (total_errors() == 0)
            $display(">>> PASS");
        else
            $display(">>> FAIL");
        $finish;
    end

endmodule

// File: sim/pt_walker_sva.sv
/*
 * Protocol assertions for the page-table walker, bound into its top level.
 * Covers the strobe rules on the read and fill ports, request readiness
 * during a walk, and the width of the not_present pulse.
 */
`timescale 1ns/1ps

module pt_walker_sva (
    input logic clk,
    input logic reset,
    input logic req_rdy,
    input logic read_rdy,
    input logic read_en,
    input logic fill_rdy,
    input logic fill_en,
    input logic not_present,
    input logic busy
);
    // Count of failed checks
    int fail_count = 0;

    // ============================================================
    // Port rules
    // ============================================================

    // Read strobe only when memory can take it
    a_read_rdy: assert property (@(posedge clk) disable iff (reset) read_en |-> read_rdy)
    else
    begin
        fail_count++;
        $error("read_en asserted without read_rdy");
    end

    // Fill strobe only when the TLB side is ready
    a_fill_rdy: assert property (@(posedge clk) disable iff (reset) fill_en |-> fill_rdy)
    else
    begin
        fail_count++;
        $error("fill_en asserted without fill_rdy");
    end

    // No new request while a walk runs
    a_busy_rdy: assert property (@(posedge clk) disable iff (reset) busy |-> !req_rdy)
    else
    begin
        fail_count++;
        $error("req_rdy high while busy");
    end

    // Single-cycle fault pulse
    a_np_pulse: assert property (@(posedge clk) disable iff (reset) not_present |=> !not_present)
    else
    begin
        fail_count++;
        $error("not_present held for more than one cycle");
    end

endmodule

bind pt_walker pt_walker_sva u_sva (.*);

// File: verilog/pt_walker.sv
/*
 * Top level of the page-table walker.
 * Registers the enable input, then joins the read-response stage and the
 * walker FSM. Host memory is read through a strobe read port; finished
 * translations leave on the fill port toward the TLB.
 */
`timescale 1ns/1ps

module pt_walker (
    input  logic                    clk,
    input  logic                    reset,

    // Configuration
    input  pt_walk_pkg::pa_page_t   pt_root,
    input  logic                    enable,

    // Translation request
    input  logic                    req_en,
    input  pt_walk_pkg::va_page_t   req_va,
    output logic                    req_rdy,

    // Table line read
    input  logic                    read_rdy,
    output logic                    read_en,
    output pt_walk_pkg::line_addr_t read_addr,
    input  logic                    read_data_en,
    input  pt_walk_pkg::line_data_t read_data,

    // TLB fill
    input  logic                    fill_rdy,
    output logic                    fill_en,
    output pt_walk_pkg::pt_fill_t   fill,

    // Status
    output logic                    not_present,
    output logic                    busy
);
    import pt_walk_pkg::*;

    logic         enable_q;
    logic         entry_valid;
    pt_entry_t    entry;
    pt_word_idx_t word_idx;

    // Walker accepts requests one cycle after enable is seen
    always_ff @(posedge clk)
    begin
        if (reset)
            enable_q <= 1'b0;
        else
            enable_q <= enable;
    end

    pt_walk_rsp_stage u_rsp (
        .clk          (clk),
        .reset        (reset),
        .read_data_en (read_data_en),
        .read_data    (read_data),
        .word_idx     (word_idx),
        .entry_valid  (entry_valid),
        .entry        (entry)
    );

    pt_walk_fsm u_fsm (
        .clk         (clk),
        .reset       (reset),
        .ready_en    (enable_q),
        .pt_root     (pt_root),
        .req_en      (req_en),
        .req_va      (req_va),
        .req_rdy     (req_rdy),
        .read_rdy    (read_rdy),
        .read_en     (read_en),
        .read_addr   (read_addr),
        .word_idx    (word_idx),
        .entry_valid (entry_valid),
        .entry       (entry),
        .fill_rdy    (fill_rdy),
        .fill_en     (fill_en),
        .fill        (fill),
        .not_present (not_present),
        .busy        (busy)
    );

endmodule

// File: verilog/pt_walk_fsm.sv
/*
 * Walker FSM for one translation at a time.
 * Latches the request, reads one table line per level at the current page,
 * adopts the next page from each decoded entry and shifts to the next level
 * index. A terminal entry leads to DONE and the fill port; an error entry
 * or a missing terminal at the last level pulses not_present and halts.
 */
`timescale 1ns/1ps

module pt_walk_fsm (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      ready_en,
    input  pt_walk_pkg::pa_page_t     pt_root,
    input  logic                      req_en,
    input  pt_walk_pkg::va_page_t     req_va,
    output logic                      req_rdy,
    input  logic                      read_rdy,
    output logic                      read_en,
    output pt_walk_pkg::line_addr_t   read_addr,
    output pt_walk_pkg::pt_word_idx_t word_idx,
    input  logic                      entry_valid,
    input  pt_walk_pkg::pt_entry_t    entry,
    input  logic                      fill_rdy,
    output logic                      fill_en,
    output pt_walk_pkg::pt_fill_t     fill,
    output logic                      not_present,
    output logic                      busy
);
    import pt_walk_pkg::*;

    walk_state_t state;

    // Level being walked, 0 is the root table
    walk_depth_t depth;

    // VA under translation
    va_page_t translate_va;

    // Remaining level indices, current one in the top slot
    pt_idx_vec_t idx_vec;

    // Table page during the walk, translated page once done
    pa_page_t cur_page;

    // Entry captured from the response stage
    pt_entry_t cur_entry;

    pt_idx_t      cur_idx;
    pt_line_idx_t cur_line;
    logic         req_accept;
    logic         last_level;
    logic         walk_fail;

    assign req_accept = req_en && req_rdy;
    assign last_level = (depth == walk_depth_t'(PT_LEVELS - 1));

    // Missing entry, or ran out of levels without a translation
    assign walk_fail = cur_entry.error || (!cur_entry.terminal && last_level);

    // Index split into line within the page and word within the line
    assign cur_idx  = idx_vec[PT_LEVELS-1];
    assign cur_line = cur_idx[PT_IDX_W-1 -: PT_LINE_IDX_W];
    assign word_idx = cur_idx[PT_WORD_IDX_W-1:0];

    // ============================================================
    // State transitions
    // ============================================================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= IDLE;
            depth <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (req_accept)
                    begin
                        state <= READ_REQ;
                        depth <= '0;
                    end
                end

                // Hold until memory takes the read
                READ_REQ:
                begin
                    if (read_en)
                        state <= WAIT_RSP;
                end

                WAIT_RSP:
                begin
                    if (entry_valid)
                        state <= RSP;
                end

                RSP:
                begin
                    if (walk_fail)
                    begin
                        state <= ERROR;
                    end
                    else if (cur_entry.terminal)
                    begin
                        // Depth stays at the final level for big_page
                        state <= DONE;
                    end
                    else
                    begin
                        state <= READ_REQ;
                        depth <= depth + walk_depth_t'(1);
                    end
                end

                // Wait for the TLB to take the fill
                DONE:
                begin
                    if (fill_en)
                        state <= IDLE;
                end

                ERROR:
                    state <= HALT;

                // Stuck here until reset
                HALT:
                    state <= HALT;

                default:
                    state <= IDLE;
            endcase
        end
    end

    // ============================================================
    // Walk registers
    // ============================================================

    always_ff @(posedge clk)
    begin
        // New request starts at the root with the top index first
        if (req_accept)
        begin
            translate_va <= req_va;
            idx_vec      <= pt_idx_vec_t'(req_va);
            cur_page     <= pt_root;
        end

        if ((state == WAIT_RSP) && entry_valid)
            cur_entry <= entry;

        if (state == RSP)
        begin
            cur_page <= cur_entry.page;

            // Next level index moves into the top slot
            for (int i = PT_LEVELS - 1; i > 0; i--)
                idx_vec[i] <= idx_vec[i-1];
            idx_vec[0] <= '0;
        end
    end

    // ============================================================
    // Ports
    // ============================================================

    assign req_rdy = ready_en && (state == IDLE);
    assign busy    = (state != IDLE);

    // Line read at current page plus line part of the level index
    assign read_en   = (state == READ_REQ) && read_rdy;
    assign read_addr = {cur_page, cur_line};

    assign fill_en = (state == DONE) && fill_rdy;

    // Single-cycle pulse, ERROR is left after one clock
    assign not_present = (state == ERROR);

    always_comb
    begin
        fill.va       = translate_va;
        fill.pa       = cur_page;
        fill.big_page = (depth == walk_depth_t'(PT_BIG_PAGE_DEPTH));
    end

endmodule

// File: verilog/pt_walk_rsp_stage.sv
/*
 * Registered read-response path of the page-table walker.
 * Stage 1 captures the returned line, stage 2 picks the addressed 64-bit
 * word and decodes it into a page and status flags.
 * entry_valid follows read_data_en by exactly two cycles.
 */
`timescale 1ns/1ps

module pt_walk_rsp_stage (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      read_data_en,
    input  pt_walk_pkg::line_data_t   read_data,
    input  pt_walk_pkg::pt_word_idx_t word_idx,
    output logic                      entry_valid,
    output pt_walk_pkg::pt_entry_t    entry
);
    import pt_walk_pkg::*;

    // Stage 1 line and strobe
    logic       data_en_q;
    line_data_t data_q;

    // Line viewed as words, and the selected word
    pt_word_t [PT_WORDS_PER_LINE-1:0] line_words;
    pt_word_t                         sel_word;
    pt_entry_t                        sel_entry;

    // ============================================================
    // Word select and decode
    // ============================================================

    always_comb
    begin
        line_words = data_q;
        sel_word   = line_words[word_idx];

        // Page field sits above the 4 KB offset
        sel_entry.page     = sel_word[PAGE_OFFSET_W +: PAGE_W];
        // Bit 3 marks a missing entry
        sel_entry.error    = sel_word[PT_ERROR_BIT];
        // Bit 0 marks the final translation
        sel_entry.terminal = sel_word[PT_TERMINAL_BIT];
    end

    // ============================================================
    // Pipeline registers
    // ============================================================

    // Strobes
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_en_q   <= 1'b0;
            entry_valid <= 1'b0;
        end
        else
        begin
            data_en_q   <= read_data_en;
            entry_valid <= data_en_q;
        end
    end

    // Payload follows the strobes one-for-one
    always_ff @(posedge clk)
    begin
        data_q <= read_data;
        entry  <= sel_entry;
    end

endmodule

// File: verilog/pt_walk_pkg.sv
/*
 * Shared widths, types and encodings for the page-table walker.
 * Addresses are 48 bits with 4 KB pages. A 36-bit page index splits into
 * four 9-bit level indices. Each level index picks one 64-bit entry, which
 * is a line of eight words plus a word within that line.
 * Modules import this package inside their body and use scoped names on ports.
 */
package pt_walk_pkg;

    // ============================================================
    // Table geometry
    // ============================================================

    localparam int PT_LEVELS         = 4;
    localparam int PT_IDX_W          = 9;
    localparam int PT_WORD_IDX_W     = 3;
    localparam int PT_LINE_IDX_W     = PT_IDX_W - PT_WORD_IDX_W;
    localparam int LINE_DATA_W       = 512;
    localparam int PT_WORD_W         = 64;
    localparam int PT_WORDS_PER_LINE = LINE_DATA_W / PT_WORD_W;

    // Address format
    localparam int ADDR_W        = 48;
    localparam int PAGE_OFFSET_W = 12;
    localparam int PAGE_W        = ADDR_W - PAGE_OFFSET_W;
    localparam int LINE_ADDR_W   = PAGE_W + PT_LINE_IDX_W;

    // Entry status bits
    localparam int PT_TERMINAL_BIT = 0;
    localparam int PT_ERROR_BIT    = 3;

    // A terminal entry found at this depth maps a 2 MB page
    localparam int PT_BIG_PAGE_DEPTH = 2;

    // ============================================================
    // Vector types
    // ============================================================

    typedef logic [PT_LEVELS*PT_IDX_W-1:0]  va_page_t;
    typedef logic [PAGE_W-1:0]              pa_page_t;
    typedef logic [LINE_ADDR_W-1:0]         line_addr_t;
    typedef logic [LINE_DATA_W-1:0]         line_data_t;
    typedef logic [PT_WORD_W-1:0]           pt_word_t;
    typedef logic [PT_IDX_W-1:0]            pt_idx_t;
    typedef logic [PT_WORD_IDX_W-1:0]       pt_word_idx_t;
    typedef logic [PT_LINE_IDX_W-1:0]       pt_line_idx_t;
    typedef logic [$clog2(PT_LEVELS)-1:0]   walk_depth_t;

    // Level indices, top level in the high slot
    typedef pt_idx_t [PT_LEVELS-1:0] pt_idx_vec_t;

    // Decoded table entry
    typedef struct packed {
        pa_page_t page;
        logic     error;
        logic     terminal;
    } pt_entry_t;

    // Translation handed to the TLB
    typedef struct packed {
        va_page_t va;
        pa_page_t pa;
        logic     big_page;
    } pt_fill_t;

    // Walker FSM
    typedef enum logic [2:0] {
        IDLE,
        READ_REQ,
        WAIT_RSP,
        RSP,
        DONE,
        ERROR,
        HALT
    } walk_state_t;

endpackage
